// ==== Makefile ====
TOP = tb_rv_decode_execute

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
		--top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== compile.f ====
hdl/rv_pkg.sv
hdl/de_bus_if.sv
hdl/instr_decoder.sv
hdl/d_e_reg.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/exec_combine.sv
hdl/rv_decode_execute.sv
tb/tb_rv_decode_execute.sv

// ==== hdl/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    de_bus_if.dst                   e,
    output logic [rv_pkg::XLEN-1:0] alu_result
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb begin
        case (e.src_a)
            SRC_A_PC:   op_a = e.pc;
            SRC_A_ZERO: op_a = '0;      // LUI
            default:    op_a = e.rs1_data;
        endcase
    end

    assign op_b  = e.src_b_imm ? e.imm : e.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (e.alu_op)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default:  alu_result = op_a + op_b;  // Also the address adder for loads and stores
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
    de_bus_if.dst e,
    output logic  cond_true
);
    import rv_pkg::*;

    logic equal;
    logic less_s;
    logic less_u;

    assign equal  = e.rs1_data == e.rs2_data;
    assign less_s = $signed(e.rs1_data) < $signed(e.rs2_data);
    assign less_u = e.rs1_data < e.rs2_data;

    always_comb begin
        case (e.branch_type)
            BR_EQ:   cond_true = equal;
            BR_NE:   cond_true = !equal;
            BR_LT:   cond_true = less_s;
            BR_GE:   cond_true = !less_s;
            BR_LTU:  cond_true = less_u;
            BR_GEU:  cond_true = !less_u;
            default: cond_true = 1'b0;
        endcase
    end

    // The decoder keeps funct3 2 and 3 out of the branch path
    always_comb begin
        if (e.branch) begin
            assert (e.branch_type[2:1] != 2'b01) else $error("reserved branch condition");
        end
    end

endmodule

`default_nettype wire

// ==== hdl/d_e_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module d_e_reg (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  flush,
    de_bus_if.dst d,
    de_bus_if.src e
);
    import rv_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            e.reg_write   <= 1'b0;
            e.mem_write   <= 1'b0;
            e.result_src  <= RES_ALU;
            e.alu_op      <= ALU_ADD;
            e.src_a       <= SRC_A_RS1;
            e.src_b_imm   <= 1'b0;
            e.branch      <= 1'b0;
            e.jump        <= 1'b0;
            e.jump_reg    <= 1'b0;
            e.branch_type <= BR_EQ;
            e.pc          <= '0;
            e.pc4         <= '0;
            e.imm         <= '0;
            e.rs1_data    <= '0;
            e.rs2_data    <= '0;
            e.rd          <= '0;
            e.ra          <= '0;
            e.rb          <= '0;
        end else if (flush || !stall) begin  // Flush wins over stall
            e.reg_write   <= d.reg_write && !flush;
            e.mem_write   <= d.mem_write && !flush;
            e.branch      <= d.branch && !flush;
            e.jump        <= d.jump && !flush;
            e.jump_reg    <= d.jump_reg && !flush;
            e.result_src  <= d.result_src;
            e.alu_op      <= d.alu_op;
            e.src_a       <= d.src_a;
            e.src_b_imm   <= d.src_b_imm;
            e.branch_type <= d.branch_type;
            e.pc          <= d.pc;
            e.pc4         <= d.pc4;
            e.imm         <= d.imm;
            e.rs1_data    <= d.rs1_data;
            e.rs2_data    <= d.rs2_data;
            e.rd          <= d.rd;
            e.ra          <= d.ra;
            e.rb          <= d.rb;
        end
    end

    // The execute stage cannot resolve a jump and a branch in the same slot
    jump_branch_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(d.jump && d.branch)
    ) else $error("decode bundle raised jump and branch together");

endmodule

`default_nettype wire

// ==== hdl/de_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface de_bus_if;
    import rv_pkg::*;

    logic            reg_write;
    logic            mem_write;
    result_src_e     result_src;
    alu_op_e         alu_op;
    src_a_e          src_a;
    logic            src_b_imm;   // Operand B is the immediate rather than rs2
    logic            branch;
    logic            jump;
    logic            jump_reg;    // JALR takes its target from the ALU
    branch_e         branch_type;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [4:0]      rd;
    logic [4:0]      ra;
    logic [4:0]      rb;

    modport src (
        output reg_write, mem_write, result_src, alu_op, src_a, src_b_imm,
               branch, jump, jump_reg, branch_type, pc, pc4, imm,
               rs1_data, rs2_data, rd, ra, rb
    );

    modport dst (
        input  reg_write, mem_write, result_src, alu_op, src_a, src_b_imm,
               branch, jump, jump_reg, branch_type, pc, pc4, imm,
               rs1_data, rs2_data, rd, ra, rb
    );

endinterface

`default_nettype wire

// ==== hdl/exec_combine.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_combine (
    de_bus_if.dst                   e,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic                    cond_true,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic [rv_pkg::XLEN-1:0] pc_target,
    output logic                    redirect
);
    import rv_pkg::*;

    // JALR target comes from rs1 plus imm with the low bit dropped
    assign pc_target = e.jump_reg ? {alu_result[XLEN-1:1], 1'b0} : e.pc + e.imm;

    assign redirect = e.jump || (e.branch && cond_true);

    // Load data is merged after this stage, so RES_MEM still shows the address
    assign result = (e.result_src == RES_PC4) ? e.pc4 : alu_result;

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  logic [rv_pkg::XLEN-1:0] instr,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    de_bus_if.src                   d
);
    import rv_pkg::*;

    instr_u          iw;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            funct7_alt;
    alu_op_e         arith_op;

    assign iw         = instr;
    assign funct7_alt = iw.r_fmt.funct7[5];

    assign imm_i = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
    assign imm_s = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
    assign imm_b = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {iw.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                    iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

    assign d.pc       = pc;
    assign d.pc4      = pc + XLEN'(4);
    assign d.rs1_data = rs1_data;
    assign d.rs2_data = rs2_data;
    assign d.rd       = iw.r_fmt.rd;
    assign d.ra       = iw.r_fmt.rs1;
    assign d.rb       = iw.r_fmt.rs2;  // Hazard unit ignores these for formats without them

    // SUB exists only with register operands, SRA in both forms
    always_comb begin
        case (iw.r_fmt.funct3)
            3'b000:  arith_op = (iw.r_fmt.opcode == OP_R && funct7_alt) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        d.reg_write   = 1'b0;  // Anything not matched below is a bubble
        d.mem_write   = 1'b0;
        d.result_src  = RES_ALU;
        d.alu_op      = ALU_ADD;
        d.src_a       = SRC_A_RS1;
        d.src_b_imm   = 1'b0;
        d.branch      = 1'b0;
        d.jump        = 1'b0;
        d.jump_reg    = 1'b0;
        d.branch_type = BR_EQ;
        d.imm         = '0;
        case (iw.r_fmt.opcode)
            OP_R: begin
                d.reg_write = 1'b1;
                d.alu_op    = arith_op;
            end
            OP_IMM: begin
                d.reg_write = 1'b1;
                d.alu_op    = arith_op;
                d.src_b_imm = 1'b1;
                d.imm       = imm_i;
            end
            OP_LOAD: begin
                d.reg_write  = 1'b1;
                d.result_src = RES_MEM;
                d.src_b_imm  = 1'b1;
                d.imm        = imm_i;
            end
            OP_STORE: begin
                d.mem_write = 1'b1;
                d.src_b_imm = 1'b1;
                d.imm       = imm_s;
            end
            OP_BRANCH: begin
                if (iw.b_fmt.funct3[2:1] != 2'b01) begin  // funct3 2 and 3 are not branches
                    d.branch      = 1'b1;
                    d.branch_type = branch_e'(iw.b_fmt.funct3);
                    d.imm         = imm_b;
                end
            end
            OP_JAL: begin
                d.reg_write  = 1'b1;
                d.jump       = 1'b1;
                d.result_src = RES_PC4;
                d.imm        = imm_j;
            end
            OP_JALR: begin
                d.reg_write  = 1'b1;
                d.jump       = 1'b1;
                d.jump_reg   = 1'b1;
                d.result_src = RES_PC4;
                d.src_b_imm  = 1'b1;
                d.imm        = imm_i;
            end
            OP_LUI: begin
                d.reg_write = 1'b1;
                d.src_a     = SRC_A_ZERO;
                d.src_b_imm = 1'b1;
                d.imm       = imm_u;
            end
            OP_AUIPC: begin
                d.reg_write = 1'b1;
                d.src_a     = SRC_A_PC;
                d.src_b_imm = 1'b1;
                d.imm       = imm_u;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/rv_decode_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     flush,
    input  logic [rv_pkg::XLEN-1:0]  instr,
    input  logic [rv_pkg::XLEN-1:0]  pc,
    input  logic [rv_pkg::XLEN-1:0]  rs1_data,
    input  logic [rv_pkg::XLEN-1:0]  rs2_data,
    output logic [rv_pkg::XLEN-1:0]  result,
    output logic [rv_pkg::XLEN-1:0]  alu_result,
    output logic [rv_pkg::XLEN-1:0]  pc_target,
    output logic [rv_pkg::XLEN-1:0]  store_data,
    output logic                     redirect,
    output logic                     reg_write_e,
    output logic                     mem_write_e,
    output rv_pkg::result_src_e      result_src_e,
    output logic [4:0]               rd_e,
    output logic [4:0]               ra_e,
    output logic [4:0]               rb_e
);

    de_bus_if d_bus ();  // Decode side of the stage register
    de_bus_if e_bus ();  // Execute side

    logic cond_true;

    instr_decoder instr_decoder_i (
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .d        (d_bus.src)
    );

    d_e_reg d_e_reg_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .d     (d_bus.dst),
        .e     (e_bus.src)
    );

    alu_unit alu_unit_i (
        .e          (e_bus.dst),
        .alu_result (alu_result)
    );

    branch_unit branch_unit_i (
        .e         (e_bus.dst),
        .cond_true (cond_true)
    );

    exec_combine exec_combine_i (
        .e          (e_bus.dst),
        .alu_result (alu_result),
        .cond_true  (cond_true),
        .result     (result),
        .pc_target  (pc_target),
        .redirect   (redirect)
    );

    assign store_data   = e_bus.rs2_data;
    assign reg_write_e  = e_bus.reg_write;
    assign mem_write_e  = e_bus.mem_write;
    assign result_src_e = e_bus.result_src;
    assign rd_e         = e_bus.rd;
    assign ra_e         = e_bus.ra;
    assign rb_e         = e_bus.rb;

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats, all views of the same 32-bit word
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // Control encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [2:0] {  // Same code as funct3 of a branch
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd4,
        BR_GE  = 3'd5,
        BR_LTU = 3'd6,
        BR_GEU = 3'd7
    } branch_e;

endpackage

`default_nettype wire

// ==== tb/tb_rv_decode_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decode_execute;
    import rv_pkg::*;

    localparam int TEST_CYCLES = 11 + 76 + 16 + 30 + 8 + 8;
    localparam int MARGIN      = 20;

    logic            clk;
    logic            rst;
    logic            stall;
    logic            flush;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] store_data;
    logic            redirect;
    logic            reg_write_e;
    logic            mem_write_e;
    result_src_e     res_src_e;
    logic [4:0]      rd_e;
    logic [4:0]      ra_e;
    logic [4:0]      rb_e;

    logic [31:0] lfsr;
    int          err_count;
    int          check_count;
    int          test_count;

    rv_decode_execute rv_decode_execute_i (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .instr        (instr),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (result),
        .alu_result   (alu_result),
        .pc_target    (pc_target),
        .store_data   (store_data),
        .redirect     (redirect),
        .reg_write_e  (reg_write_e),
        .mem_write_e  (mem_write_e),
        .result_src_e (res_src_e),
        .rd_e         (rd_e),
        .ra_e         (ra_e),
        .rb_e         (rb_e)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
        return $unsigned($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] r2, r1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        instr_u iw;
        iw.r_fmt = '{funct7: f7, rs2: r2, rs1: r1, funct3: f3, rd: rd, opcode: op};
        return iw;
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] r1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        instr_u iw;
        iw.i_fmt = '{imm_11_0: imm, rs1: r1, funct3: f3, rd: rd, opcode: op};
        return iw;
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] r2, r1);
        instr_u iw;
        iw.s_fmt = '{imm_11_5: imm[11:5], rs2: r2, rs1: r1, funct3: 3'b010,
                     imm_4_0: imm[4:0], opcode: OP_STORE};
        return iw;
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] r2, r1,
                                             input logic [2:0] f3);
        instr_u iw;
        iw.b_fmt = '{imm_12: imm[12], imm_10_5: imm[10:5], rs2: r2, rs1: r1, funct3: f3,
                     imm_4_1: imm[4:1], imm_11: imm[11], opcode: OP_BRANCH};
        return iw;
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
        instr_u iw;
        iw.u_fmt = '{imm_31_12: imm, rd: rd, opcode: op};
        return iw;
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        instr_u iw;
        iw.j_fmt = '{imm_20: imm[20], imm_10_1: imm[10:1], imm_11: imm[11],
                     imm_19_12: imm[19:12], rd: rd, opcode: OP_JAL};
        return iw;
    endfunction

    // RV32I integer operation for a funct3 and the alternate bit of funct7
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                else return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Inputs change on the falling edge, outputs are read just after the rising one
    task automatic step(input logic st, fl, input logic [31:0] iw, pc_v, a, b);
        @(negedge clk);
        stall    = st;
        flush    = fl;
        instr    = iw;
        pc       = pc_v;
        rs1_data = a;
        rs2_data = b;
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_res_src(input string name, input result_src_e got, exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_idle();
        check_bit("reg_write_e", reg_write_e, 1'b0);
        check_bit("mem_write_e", mem_write_e, 1'b0);
        check_bit("redirect", redirect, 1'b0);
    endtask

    task automatic check_jalr(input logic [31:0] pc_v, a, b, input logic [11:0] imm,
                              input logic [4:0] rd, r1);
        logic [31:0] addr;
        addr = a + sext(32'(imm), 12);
        check_word("alu_result", alu_result, addr);
        check_word("pc_target", pc_target, addr & ~32'd1);
        check_word("result", result, pc_v + 32'd4);
        check_word("store_data", store_data, b);
        check_bit("redirect", redirect, 1'b1);
        check_bit("reg_write_e", reg_write_e, 1'b1);
        check_bit("mem_write_e", mem_write_e, 1'b0);
        check_res_src("result_src_e", res_src_e, RES_PC4);
        check_reg("rd_e", rd_e, rd);
        check_reg("ra_e", ra_e, r1);
        check_reg("rb_e", rb_e, imm[4:0]);  // Bits 24:20 of the word
    endtask

    task automatic finish_test(input string name, input int start);
        test_count++;
        $display("test %-12s done, %0d errors", name, err_count - start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int start;
        start = err_count;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle();
        finish_test("reset", start);
    endtask

    task automatic test_alu();
        logic [3:0]  ops [10];
        logic [31:0] a, b, exp, iw;
        logic [4:0]  rd, r1, r2;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        int          start;
        start = err_count;
        ops   = '{4'h0, 4'h8, 4'h7, 4'h6, 4'h4, 4'h1, 4'h5, 4'hd, 4'h2, 4'h3};  // Bit 3 is alt
        for (int k = 0; k < 10; k++) begin
            f3  = ops[k][2:0];
            alt = ops[k][3];
            repeat (4) begin
                a  = rand_bits(32);
                b  = rand_bits(32);
                rd = 5'(rand_bits(5));
                r1 = 5'(rand_bits(5));
                r2 = 5'(rand_bits(5));
                iw = encode_r({1'b0, alt, 5'b0}, r2, r1, f3, rd, OP_R);
                step(1'b0, 1'b0, iw, 32'h0, a, b);
                exp = ref_alu(f3, alt, a, b);
                check_word("alu_result", alu_result, exp);
                check_word("result", result, exp);
                check_bit("reg_write_e", reg_write_e, 1'b1);
                check_reg("rd_e", rd_e, rd);
                check_reg("ra_e", ra_e, r1);
                check_reg("rb_e", rb_e, r2);
                if (!(f3 == 3'd0 && alt)) begin  // There is no SUBI
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, 5'(rand_bits(5))};
                    else imm = 12'(rand_bits(12));
                    iw = encode_i(imm, r1, f3, rd, OP_IMM);
                    step(1'b0, 1'b0, iw, 32'h0, a, b);
                    exp = ref_alu(f3, alt && f3 == 3'd5, a, sext(32'(imm), 12));
                    check_word("alu_result", alu_result, exp);
                    check_word("result", result, exp);
                    check_bit("reg_write_e", reg_write_e, 1'b1);
                    check_reg("rd_e", rd_e, rd);
                    check_reg("ra_e", ra_e, r1);
                end
            end
        end
        finish_test("alu", start);
    endtask

    task automatic test_upper_mem();
        logic [31:0] a, b, pc_v, exp;
        logic [19:0] imm20;
        logic [11:0] imm;
        logic [4:0]  rd, r1, r2;
        int          start;
        start = err_count;
        repeat (4) begin
            a     = rand_bits(32);
            b     = rand_bits(32);
            pc_v  = rand_bits(30) << 2;
            imm20 = 20'(rand_bits(20));
            imm   = 12'(rand_bits(12));
            rd    = 5'(rand_bits(5));
            r1    = 5'(rand_bits(5));
            r2    = 5'(rand_bits(5));
            step(1'b0, 1'b0, encode_u(imm20, rd, OP_LUI), pc_v, a, b);
            check_word("result", result, {imm20, 12'b0});
            check_bit("reg_write_e", reg_write_e, 1'b1);
            check_reg("rd_e", rd_e, rd);
            step(1'b0, 1'b0, encode_u(imm20, rd, OP_AUIPC), pc_v, a, b);
            check_word("result", result, pc_v + {imm20, 12'b0});
            exp = a + sext(32'(imm), 12);
            step(1'b0, 1'b0, encode_i(imm, r1, 3'b010, rd, OP_LOAD), pc_v, a, b);
            check_word("alu_result", alu_result, exp);
            check_res_src("result_src_e", res_src_e, RES_MEM);
            check_bit("reg_write_e", reg_write_e, 1'b1);
            check_bit("mem_write_e", mem_write_e, 1'b0);
            step(1'b0, 1'b0, encode_s(imm, r2, r1), pc_v, a, b);
            check_word("alu_result", alu_result, exp);
            check_word("store_data", store_data, b);
            check_bit("mem_write_e", mem_write_e, 1'b1);
            check_bit("reg_write_e", reg_write_e, 1'b0);
        end
        finish_test("upper_mem", start);
    endtask

    task automatic test_branch();
        logic [2:0]  conds [6];
        logic [31:0] a, b, r, pc_v;
        logic [12:0] imm;
        int          start;
        start = err_count;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (conds[c]) begin
            for (int p = 0; p < 5; p++) begin
                r    = rand_bits(30);
                pc_v = rand_bits(30) << 2;
                imm  = {12'(rand_bits(12)), 1'b0};
                case (p)
                    0: begin
                        a = r;
                        b = r;
                    end
                    1: begin
                        a = r;
                        b = r + 32'd1;
                    end
                    2: begin
                        a = r + 32'd1;
                        b = r;
                    end
                    3: begin  // Less signed, greater unsigned
                        a = r | 32'h8000_0000;
                        b = r;
                    end
                    default: begin
                        a = r;
                        b = r | 32'h8000_0000;
                    end
                endcase
                step(1'b0, 1'b0, encode_b(imm, 5'd2, 5'd1, conds[c]), pc_v, a, b);
                check_bit("redirect", redirect, ref_branch(conds[c], a, b));
                check_word("pc_target", pc_target, pc_v + sext(32'(imm), 13));
                check_bit("reg_write_e", reg_write_e, 1'b0);
                check_bit("mem_write_e", mem_write_e, 1'b0);
            end
        end
        finish_test("branch", start);
    endtask

    task automatic test_jump();
        logic [31:0] a, b, pc_v;
        logic [20:0] imm21;
        logic [11:0] imm;
        logic [4:0]  rd, r1;
        int          start;
        start = err_count;
        repeat (4) begin
            a     = rand_bits(32);
            b     = rand_bits(32);
            pc_v  = rand_bits(30) << 2;
            imm21 = {20'(rand_bits(20)), 1'b0};
            imm   = 12'(rand_bits(12));
            rd    = 5'(rand_bits(5));
            r1    = 5'(rand_bits(5));
            step(1'b0, 1'b0, encode_j(imm21, rd), pc_v, a, b);
            check_bit("redirect", redirect, 1'b1);
            check_word("result", result, pc_v + 32'd4);
            check_word("pc_target", pc_target, pc_v + sext(32'(imm21), 21));
            check_bit("reg_write_e", reg_write_e, 1'b1);
            check_reg("rd_e", rd_e, rd);
            step(1'b0, 1'b0, encode_i(imm, r1, 3'b000, rd, OP_JALR), pc_v, a, b);
            check_jalr(pc_v, a, b, imm, rd, r1);
        end
        finish_test("jump", start);
    endtask

    task automatic test_stall_flush();
        logic [31:0] a, b, pc_v;
        logic [11:0] imm;
        logic [4:0]  rd, r1;
        int          start;
        start = err_count;
        a    = rand_bits(32);
        b    = rand_bits(32);
        pc_v = rand_bits(30) << 2;
        imm  = 12'(rand_bits(12));
        rd   = 5'(rand_bits(5));
        r1   = 5'(rand_bits(5));
        step(1'b0, 1'b0, encode_i(imm, r1, 3'b000, rd, OP_JALR), pc_v, a, b);
        check_jalr(pc_v, a, b, imm, rd, r1);
        repeat (3) begin  // New inputs every cycle, the held JALR must stay visible
            step(1'b1, 1'b0, encode_r(7'h20, 5'd3, 5'd4, 3'd0, 5'd5, OP_R),
                 rand_bits(32), rand_bits(32), rand_bits(32));
            check_jalr(pc_v, a, b, imm, rd, r1);
        end
        step(1'b0, 1'b1, encode_j(21'h000100, 5'd1), pc_v, a, b);
        check_idle();
        step(1'b1, 1'b1, encode_s(12'h010, 5'd2, 5'd3), pc_v, a, b);
        check_idle();
        check_word("alu_result", alu_result, a + 32'd16);  // The store's address proves flush won
        step(1'b0, 1'b0, {25'(rand_bits(25)), 7'b1110011}, pc_v, a, b);
        check_idle();
        step(1'b0, 1'b0, {25'(rand_bits(25)), 7'b0001111}, pc_v, a, b);
        check_idle();
        finish_test("stall_flush", start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        lfsr        = 32'h8c7c2329;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_reset();
        test_alu();
        test_upper_mem();
        test_branch();
        test_jump();
        test_stall_flush();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 100);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
